// File: hdl/dec_pkg.sv
/*
  Shared widths, RV32I opcodes, decode enums and stage packets.
  IB_DEPTH must be a power of two; the buffer pointers wrap naturally.
  Only OP, OP-IMM, LUI, LOAD, STORE, BRANCH and JAL are decoded.
*/

package dec_pkg;

   // ************************************************************
   // widths
   // ************************************************************
   localparam int XLEN     = 32;                        // data width
   localparam int PC_W     = 31;                        // pc bits 31:1
   localparam int REG_W    = 5;                         // register index
   localparam int IB_DEPTH = 4;                         // fetch buffer entries
   localparam int IB_PTR_W = $clog2(IB_DEPTH);          // buffer pointer
   localparam int IB_CNT_W = $clog2(IB_DEPTH + 1);      // occupancy, 0..IB_DEPTH

   typedef logic [IB_PTR_W-1:0] ib_ptr_t;
   typedef logic [IB_CNT_W-1:0] ib_cnt_t;

   // ************************************************************
   // major opcodes, low two bits always 11
   // ************************************************************
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;

   typedef enum logic [1:0] {
      UNIT_NONE = 2'd0,                                 // illegal, nothing to run
      UNIT_ALU  = 2'd1,
      UNIT_LSU  = 2'd2,                                 // address add
      UNIT_BR   = 2'd3                                  // branch compare, jal
   } unit_t;

   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_SLL  = 4'd2,
      ALU_SLT  = 4'd3,
      ALU_SLTU = 4'd4,
      ALU_XOR  = 4'd5,
      ALU_SRL  = 4'd6,
      ALU_SRA  = 4'd7,
      ALU_OR   = 4'd8,
      ALU_AND  = 4'd9
   } alu_op_t;

   // ************************************************************
   // stage packets
   // ************************************************************
   typedef struct packed {
      logic [XLEN-1:0] instr;                           // raw instruction
      logic [PC_W-1:0] pc;
   } ib_pkt_t;

   typedef struct packed {
      logic [PC_W-1:0]  pc;
      logic [REG_W-1:0] rs1;
      logic [REG_W-1:0] rs2;
      logic [REG_W-1:0] rd;
      logic             rs1_en;
      logic             rs2_en;
      logic             rd_en;
      logic [XLEN-1:0]  imm;                            // sign extended
      unit_t            unit;
      alu_op_t          alu_op;
      logic             illegal;                        // all enables cleared
   } dec_pkt_t;

   typedef struct packed {
      dec_pkt_t        dec;
      logic [XLEN-1:0] rs1_data;                        // zero when rs1 disabled
      logic [XLEN-1:0] rs2_data;
   } iss_pkt_t;

endpackage

// File: hdl/dec_stage_if.sv
/*
  Valid/hold link between pipeline stages.
  A transfer happens on each edge with valid high and hold low.
  Source keeps valid and payload steady while hold is high.
*/
`timescale 1ns/100ps

interface dec_stage_if #(
   parameter type payload_t = logic
) ();

   logic     valid;                                     // payload present
   payload_t payload;
   logic     hold;                                      // back-pressure from consumer
   logic     flush;                                     // drop everything not yet issued

   modport src (
      output valid,
      output payload,
      input  hold,
      input  flush
   );

   // consumer sees flush too, the issue register needs it
   modport dst (
      input  valid,
      input  payload,
      output hold,
      input  flush
   );

   modport ctl (
      output flush
   );

endinterface

// File: hdl/dec_ib_ctl.sv
/*
  Four-phase fetch capture into a small circular instruction buffer.
  Fetch side must keep instr and pc stable while req is high.
  Buffer full holds ack low. An entry written during flush is dropped.
*/
`timescale 1ns/100ps

module dec_ib_ctl (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      ifu_req,           // fetch request, four phase
   input  logic [dec_pkg::XLEN-1:0]  ifu_instr,
   input  logic [dec_pkg::PC_W-1:0]  ifu_pc,
   output logic                      ifu_ack,
   dec_stage_if.src                  ib_out             // oldest entry to decode
);

   dec_pkg::ib_pkt_t ib_mem [dec_pkg::IB_DEPTH];        // entry storage
   dec_pkg::ib_ptr_t ib_wptr;
   dec_pkg::ib_ptr_t ib_rptr;
   dec_pkg::ib_cnt_t ib_cnt;
   logic             ib_full;
   logic             ib_wr;                             // capture this edge
   logic             ib_pop;                            // decode takes oldest

   // ************************************************************
   // fetch handshake
   // ************************************************************
   assign ib_full = (ib_cnt == dec_pkg::ib_cnt_t'(dec_pkg::IB_DEPTH));
   assign ib_wr   = ifu_req & ~ifu_ack & ~ib_full;      // one write per request

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ifu_ack <= 1'b0;
      end else if (ib_wr) begin
         ifu_ack <= 1'b1;                               // ack with the write
      end else if (!ifu_req) begin
         ifu_ack <= 1'b0;                               // req seen low, close out
      end
   end

   // ************************************************************
   // buffer
   // ************************************************************
   assign ib_pop        = ib_out.valid & ~ib_out.hold;
   assign ib_out.valid  = (ib_cnt != '0);
   assign ib_out.payload = ib_mem[ib_rptr];

   always_ff @(posedge clk) begin
      if (ib_wr) begin
         ib_mem[ib_wptr] <= '{instr: ifu_instr, pc: ifu_pc};
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ib_wptr <= '0;
         ib_rptr <= '0;
         ib_cnt  <= '0;
      end else if (ib_out.flush) begin
         ib_wptr <= '0;                                 // empty, drop capture too
         ib_rptr <= '0;
         ib_cnt  <= '0;
      end else begin
         if (ib_wr) begin
            ib_wptr <= ib_wptr + dec_pkg::ib_ptr_t'(1);
         end
         if (ib_pop) begin
            ib_rptr <= ib_rptr + dec_pkg::ib_ptr_t'(1);
         end
         case ({ib_wr, ib_pop})
            2'b10:   ib_cnt <= ib_cnt + dec_pkg::ib_cnt_t'(1);
            2'b01:   ib_cnt <= ib_cnt - dec_pkg::ib_cnt_t'(1);
            default: ib_cnt <= ib_cnt;                  // both or neither
         endcase
      end
   end

endmodule

// File: hdl/dec_decode_ctl.sv
/*
  RV32I decode of the kept opcodes into a decode packet, one stage register.
  Any other opcode, low bits not 11, or a bad funct7 sets illegal.
  Illegal packets carry no register enables and unit none.
*/
`timescale 1ns/100ps

module dec_decode_ctl (
   input  logic     clk,
   input  logic     rst_n,
   dec_stage_if.dst ib_in,                              // from instruction buffer
   dec_stage_if.src dec_out                             // to operand read
);

   logic [dec_pkg::XLEN-1:0] instr;
   logic [6:0]               opc;
   logic [2:0]               f3;
   logic [6:0]               f7;
   logic                     f7_ok;                     // 0000000 or 0100000
   logic [dec_pkg::XLEN-1:0] imm_i;
   logic [dec_pkg::XLEN-1:0] imm_s;
   logic [dec_pkg::XLEN-1:0] imm_b;
   logic [dec_pkg::XLEN-1:0] imm_j;
   logic [dec_pkg::XLEN-1:0] imm_u;
   dec_pkg::dec_pkt_t        dec_nxt;
   dec_pkg::dec_pkt_t        dec_pkt;
   logic                     dec_vld;
   logic                     ib_xfer;

   // funct3 to alu op, alt picks sub/sra
   function automatic dec_pkg::alu_op_t alu_sel(input logic [2:0] fn3, input logic alt);
      case (fn3)
         3'b000:  return alt ? dec_pkg::ALU_SUB : dec_pkg::ALU_ADD;
         3'b001:  return dec_pkg::ALU_SLL;
         3'b010:  return dec_pkg::ALU_SLT;
         3'b011:  return dec_pkg::ALU_SLTU;
         3'b100:  return dec_pkg::ALU_XOR;
         3'b101:  return alt ? dec_pkg::ALU_SRA : dec_pkg::ALU_SRL;
         3'b110:  return dec_pkg::ALU_OR;
         default: return dec_pkg::ALU_AND;
      endcase
   endfunction

   assign instr = ib_in.payload.instr;
   assign opc   = instr[6:0];
   assign f3    = instr[14:12];
   assign f7    = instr[31:25];
   assign f7_ok = (f7 == 7'b0000000) | (f7 == 7'b0100000);

   // ************************************************************
   // immediates, sign extended from bit 31
   // ************************************************************
   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
   assign imm_u = {instr[31:12], 12'b0};

   always_comb begin
      dec_nxt        = '0;
      dec_nxt.pc     = ib_in.payload.pc;
      dec_nxt.rs1    = instr[19:15];
      dec_nxt.rs2    = instr[24:20];
      dec_nxt.rd     = instr[11:7];
      dec_nxt.unit   = dec_pkg::UNIT_NONE;
      dec_nxt.alu_op = dec_pkg::ALU_ADD;                // address add, lui, jal
      case (opc)
         dec_pkg::OPC_OP: begin
            dec_nxt.unit    = dec_pkg::UNIT_ALU;
            dec_nxt.rs1_en  = 1'b1;
            dec_nxt.rs2_en  = 1'b1;
            dec_nxt.rd_en   = 1'b1;
            dec_nxt.alu_op  = alu_sel(f3, f7[5]);
            dec_nxt.illegal = ~f7_ok;
         end
         dec_pkg::OPC_OP_IMM: begin
            dec_nxt.unit    = dec_pkg::UNIT_ALU;
            dec_nxt.rs1_en  = 1'b1;
            dec_nxt.rd_en   = 1'b1;
            dec_nxt.imm     = imm_i;
            dec_nxt.alu_op  = alu_sel(f3, f7[5] & (f3 == 3'b101)); // no subi
            dec_nxt.illegal = (f3[1:0] == 2'b01) & ~f7_ok;         // shifts only
         end
         dec_pkg::OPC_LUI: begin
            dec_nxt.unit    = dec_pkg::UNIT_ALU;        // 0 + imm
            dec_nxt.rd_en   = 1'b1;
            dec_nxt.imm     = imm_u;
         end
         dec_pkg::OPC_LOAD: begin
            dec_nxt.unit    = dec_pkg::UNIT_LSU;
            dec_nxt.rs1_en  = 1'b1;
            dec_nxt.rd_en   = 1'b1;
            dec_nxt.imm     = imm_i;
         end
         dec_pkg::OPC_STORE: begin
            dec_nxt.unit    = dec_pkg::UNIT_LSU;
            dec_nxt.rs1_en  = 1'b1;
            dec_nxt.rs2_en  = 1'b1;
            dec_nxt.imm     = imm_s;
         end
         dec_pkg::OPC_BRANCH: begin
            dec_nxt.unit    = dec_pkg::UNIT_BR;
            dec_nxt.rs1_en  = 1'b1;
            dec_nxt.rs2_en  = 1'b1;
            dec_nxt.imm     = imm_b;
            dec_nxt.alu_op  = dec_pkg::ALU_SUB;         // compare
         end
         dec_pkg::OPC_JAL: begin
            dec_nxt.unit    = dec_pkg::UNIT_BR;
            dec_nxt.rd_en   = 1'b1;                     // link
            dec_nxt.imm     = imm_j;
         end
         default: dec_nxt.illegal = 1'b1;
      endcase
      if (instr[1:0] != 2'b11) begin
         dec_nxt.illegal = 1'b1;                        // compressed not supported
      end
      if (dec_nxt.illegal) begin
         dec_nxt.rs1_en = 1'b0;
         dec_nxt.rs2_en = 1'b0;
         dec_nxt.rd_en  = 1'b0;
         dec_nxt.unit   = dec_pkg::UNIT_NONE;
      end
   end

   // ************************************************************
   // stage register
   // ************************************************************
   assign ib_xfer         = ib_in.valid & ~ib_in.hold;
   assign ib_in.hold      = dec_vld & dec_out.hold;     // stall ripples back
   assign dec_out.valid   = dec_vld;
   assign dec_out.payload = dec_pkt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dec_vld <= 1'b0;
      end else if (dec_out.flush) begin
         dec_vld <= 1'b0;
      end else if (ib_xfer) begin
         dec_vld <= 1'b1;                               // refill as old one leaves
      end else if (!dec_out.hold) begin
         dec_vld <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (ib_xfer) begin
         dec_pkt <= dec_nxt;
      end
   end

endmodule

// File: hdl/dec_gpr_ctl.sv
/*
  Integer register file, x1..x31, two combinational reads, one write.
  Writes land at the clock edge. x0 reads zero and ignores writes.
*/
`timescale 1ns/100ps

module dec_gpr_ctl (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [dec_pkg::REG_W-1:0]  rs1,
   input  logic [dec_pkg::REG_W-1:0]  rs2,
   output logic [dec_pkg::XLEN-1:0]   rs1_data,
   output logic [dec_pkg::XLEN-1:0]   rs2_data,
   input  logic                       wb_wen,
   input  logic [dec_pkg::REG_W-1:0]  wb_waddr,
   input  logic [dec_pkg::XLEN-1:0]   wb_wdata
);

   logic [dec_pkg::XLEN-1:0] gpr [1:2**dec_pkg::REG_W-1]; // no x0 storage

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 1; i < 2**dec_pkg::REG_W; i++) begin
            gpr[i] <= '0;
         end
      end else if (wb_wen && (wb_waddr != '0)) begin
         gpr[wb_waddr] <= wb_wdata;                     // x0 write dropped
      end
   end

   assign rs1_data = (rs1 == '0) ? '0 : gpr[rs1];
   assign rs2_data = (rs2 == '0) ? '0 : gpr[rs2];

endmodule

// File: hdl/dec_issue_ctl.sv
/*
  Operand read with writeback bypass, issue register, four-phase issue.
  Fields stay stable from load until ack is seen high.
  Flush clears a loaded packet only while req is still low.
*/
`timescale 1ns/100ps

module dec_issue_ctl (
   input  logic                       clk,
   input  logic                       rst_n,
   dec_stage_if.dst                   dec_in,           // decode packet
   output logic [dec_pkg::REG_W-1:0]  rs1,              // register file read
   output logic [dec_pkg::REG_W-1:0]  rs2,
   input  logic [dec_pkg::XLEN-1:0]   rs1_data,
   input  logic [dec_pkg::XLEN-1:0]   rs2_data,
   input  logic                       wb_wen,
   input  logic [dec_pkg::REG_W-1:0]  wb_waddr,
   input  logic [dec_pkg::XLEN-1:0]   wb_wdata,
   output logic                       iss_req,
   input  logic                       iss_ack,
   output dec_pkg::iss_pkt_t          iss_pkt
);

   logic                     iss_full;                  // issue register holds a packet
   logic                     dec_xfer;
   logic [dec_pkg::XLEN-1:0] rs1_opnd;
   logic [dec_pkg::XLEN-1:0] rs2_opnd;

   // disabled -> 0, same-cycle writeback -> wb data, else file
   function automatic logic [dec_pkg::XLEN-1:0] opnd_sel(
      input logic                      en,
      input logic [dec_pkg::REG_W-1:0] idx,
      input logic [dec_pkg::XLEN-1:0]  rf_data
   );
      if (!en) begin
         return '0;
      end
      if (wb_wen && (wb_waddr == idx) && (idx != '0)) begin
         return wb_wdata;
      end
      return rf_data;
   endfunction

   assign rs1      = dec_in.payload.rs1;
   assign rs2      = dec_in.payload.rs2;
   assign rs1_opnd = opnd_sel(dec_in.payload.rs1_en, dec_in.payload.rs1, rs1_data);
   assign rs2_opnd = opnd_sel(dec_in.payload.rs2_en, dec_in.payload.rs2, rs2_data);

   // ************************************************************
   // issue register and handshake
   // ************************************************************
   assign dec_in.hold = iss_full;                       // one issue in flight
   assign dec_xfer    = dec_in.valid & ~iss_full & ~dec_in.flush;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         iss_full <= 1'b0;
         iss_req  <= 1'b0;
      end else if (iss_req && iss_ack) begin
         iss_req  <= 1'b0;                              // ack seen, drop req
         iss_full <= 1'b0;
      end else if (iss_full && !iss_req) begin
         if (dec_in.flush) begin
            iss_full <= 1'b0;                           // not presented yet
         end else if (!iss_ack) begin
            iss_req <= 1'b1;                            // previous ack back low
         end
      end else if (dec_xfer) begin
         iss_full <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (dec_xfer) begin
         iss_pkt.dec      <= dec_in.payload;
         iss_pkt.rs1_data <= rs1_opnd;                  // sampled on transfer edge
         iss_pkt.rs2_data <= rs2_opnd;
      end
   end

endmodule

// File: hdl/dec_top.sv
/*
  Decode unit top: fetch buffer, decode, register file and issue.
  Both outer boundaries are four-phase req/ack; stages use valid/hold.
  Empty pipe gives iss_req three cycles after ifu_ack rises.
*/
`timescale 1ns/100ps

module dec_top (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       flush,            // drop all not yet presented
   input  logic                       ifu_req,
   input  logic [dec_pkg::XLEN-1:0]   ifu_instr,
   input  logic [dec_pkg::PC_W-1:0]   ifu_pc,
   output logic                       ifu_ack,
   input  logic                       wb_wen,
   input  logic [dec_pkg::REG_W-1:0]  wb_waddr,
   input  logic [dec_pkg::XLEN-1:0]   wb_wdata,
   output logic                       iss_req,
   input  logic                       iss_ack,
   output logic [dec_pkg::PC_W-1:0]   iss_pc,
   output dec_pkg::unit_t             iss_unit,
   output dec_pkg::alu_op_t           iss_alu_op,
   output logic [dec_pkg::REG_W-1:0]  iss_rd,
   output logic                       iss_rd_en,
   output logic [dec_pkg::XLEN-1:0]   iss_imm,
   output logic [dec_pkg::XLEN-1:0]   iss_rs1_data,
   output logic [dec_pkg::XLEN-1:0]   iss_rs2_data,
   output logic                       iss_illegal
);

   dec_stage_if #(.payload_t(dec_pkg::ib_pkt_t))  ib2dec ();
   dec_stage_if #(.payload_t(dec_pkg::dec_pkt_t)) dec2iss ();

   logic [dec_pkg::REG_W-1:0] rs1;
   logic [dec_pkg::REG_W-1:0] rs2;
   logic [dec_pkg::XLEN-1:0]  rs1_data;
   logic [dec_pkg::XLEN-1:0]  rs2_data;
   dec_pkg::iss_pkt_t         iss_pkt;

   assign ib2dec.flush  = flush;
   assign dec2iss.flush = flush;

   dec_ib_ctl i_ib (
      .clk       (clk),
      .rst_n     (rst_n),
      .ifu_req   (ifu_req),
      .ifu_instr (ifu_instr),
      .ifu_pc    (ifu_pc),
      .ifu_ack   (ifu_ack),
      .ib_out    (ib2dec)
   );

   dec_decode_ctl i_decode (
      .clk     (clk),
      .rst_n   (rst_n),
      .ib_in   (ib2dec),
      .dec_out (dec2iss)
   );

   dec_gpr_ctl i_gpr (
      .clk      (clk),
      .rst_n    (rst_n),
      .rs1      (rs1),
      .rs2      (rs2),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .wb_wen   (wb_wen),
      .wb_waddr (wb_waddr),
      .wb_wdata (wb_wdata)
   );

   dec_issue_ctl i_issue (
      .clk      (clk),
      .rst_n    (rst_n),
      .dec_in   (dec2iss),
      .rs1      (rs1),
      .rs2      (rs2),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .wb_wen   (wb_wen),
      .wb_waddr (wb_waddr),
      .wb_wdata (wb_wdata),
      .iss_req  (iss_req),
      .iss_ack  (iss_ack),
      .iss_pkt  (iss_pkt)
   );

   // ************************************************************
   // issue fields out of the packet
   // ************************************************************
   assign iss_pc       = iss_pkt.dec.pc;
   assign iss_unit     = iss_pkt.dec.unit;
   assign iss_alu_op   = iss_pkt.dec.alu_op;
   assign iss_rd       = iss_pkt.dec.rd;
   assign iss_rd_en    = iss_pkt.dec.rd_en;
   assign iss_imm      = iss_pkt.dec.imm;
   assign iss_rs1_data = iss_pkt.rs1_data;
   assign iss_rs2_data = iss_pkt.rs2_data;
   assign iss_illegal  = iss_pkt.dec.illegal;

endmodule

// File: bench/dec_tb_table.svh
/*
  Decode table for the testbench: one row per instruction.
  Columns are instr, pc[31:1], unit, alu_op, rd, rd_en, imm, illegal, rs1, rs2.
  rs1/rs2 of 0 mean the source reads zero. Illegal rows check only pc and flag.
*/
`ifndef DEC_TB_TABLE_SVH
`define DEC_TB_TABLE_SVH

typedef struct {
   logic [31:0]      instr;
   logic [30:0]      pc;
   dec_pkg::unit_t   unit;
   dec_pkg::alu_op_t alu_op;
   logic [4:0]       rd;
   logic             rd_en;
   logic [31:0]      imm;
   logic             illegal;
   logic [4:0]       rs1;                               // 0 -> expect zero data
   logic [4:0]       rs2;
} row_t;

localparam int ROWS = 14;

row_t rows [ROWS] = '{
   '{32'h002082b3, 31'h040, dec_pkg::UNIT_ALU,  dec_pkg::ALU_ADD,  5'd5,  1'b1, 32'h00000000, 1'b0, 5'd1, 5'd2}, // add
   '{32'h40418333, 31'h042, dec_pkg::UNIT_ALU,  dec_pkg::ALU_SUB,  5'd6,  1'b1, 32'h00000000, 1'b0, 5'd3, 5'd4}, // sub
   '{32'h4030d3b3, 31'h044, dec_pkg::UNIT_ALU,  dec_pkg::ALU_SRA,  5'd7,  1'b1, 32'h00000000, 1'b0, 5'd1, 5'd3}, // sra
   '{32'hffb10413, 31'h046, dec_pkg::UNIT_ALU,  dec_pkg::ALU_ADD,  5'd8,  1'b1, 32'hfffffffb, 1'b0, 5'd2, 5'd0}, // addi -5
   '{32'h40325493, 31'h048, dec_pkg::UNIT_ALU,  dec_pkg::ALU_SRA,  5'd9,  1'b1, 32'h00000403, 1'b0, 5'd4, 5'd0}, // srai
   '{32'h12345537, 31'h04a, dec_pkg::UNIT_ALU,  dec_pkg::ALU_ADD,  5'd10, 1'b1, 32'h12345000, 1'b0, 5'd0, 5'd0}, // lui
   '{32'hffc1a583, 31'h04c, dec_pkg::UNIT_LSU,  dec_pkg::ALU_ADD,  5'd11, 1'b1, 32'hfffffffc, 1'b0, 5'd3, 5'd0}, // lw
   '{32'h0020a423, 31'h04e, dec_pkg::UNIT_LSU,  dec_pkg::ALU_ADD,  5'd8,  1'b0, 32'h00000008, 1'b0, 5'd1, 5'd2}, // sw
   '{32'hfe2088e3, 31'h050, dec_pkg::UNIT_BR,   dec_pkg::ALU_SUB,  5'd17, 1'b0, 32'hfffffff0, 1'b0, 5'd1, 5'd2}, // beq
   '{32'h001000ef, 31'h052, dec_pkg::UNIT_BR,   dec_pkg::ALU_ADD,  5'd1,  1'b1, 32'h00000800, 1'b0, 5'd0, 5'd0}, // jal
   '{32'h00300633, 31'h054, dec_pkg::UNIT_ALU,  dec_pkg::ALU_ADD,  5'd12, 1'b1, 32'h00000000, 1'b0, 5'd0, 5'd3}, // x0 src
   '{32'h0000007f, 31'h056, dec_pkg::UNIT_NONE, dec_pkg::ALU_ADD,  5'd0,  1'b0, 32'h00000000, 1'b1, 5'd0, 5'd0}, // bad opc
   '{32'h002082b2, 31'h058, dec_pkg::UNIT_NONE, dec_pkg::ALU_ADD,  5'd0,  1'b0, 32'h00000000, 1'b1, 5'd0, 5'd0}, // low 10
   '{32'h022082b3, 31'h05a, dec_pkg::UNIT_NONE, dec_pkg::ALU_ADD,  5'd0,  1'b0, 32'h00000000, 1'b1, 5'd0, 5'd0}  // funct7
};

`endif

// File: bench/dec_tb.sv
/*
  Testbench for the decode unit: fetch driver, writeback, issue responder.
  Expected fields come from the table, operand data from a shadow register file.
  Issue ack delay is random in 0..3 cycles.
*/
`timescale 1ns/100ps

module dec_tb;

   logic        clk;
   logic        rst_n;
   logic        flush;
   logic        ifu_req;
   logic [31:0] ifu_instr;
   logic [30:0] ifu_pc;
   logic        ifu_ack;
   logic        wb_wen;
   logic [4:0]  wb_waddr;
   logic [31:0] wb_wdata;
   logic        iss_req;
   logic        iss_ack;
   logic [30:0] iss_pc;
   dec_pkg::unit_t   iss_unit;
   dec_pkg::alu_op_t iss_alu_op;
   logic [4:0]  iss_rd;
   logic        iss_rd_en;
   logic [31:0] iss_imm;
   logic [31:0] iss_rs1_data;
   logic [31:0] iss_rs2_data;
   logic        iss_illegal;

   `include "dec_tb_table.svh"

   logic [31:0] shadow [32];                            // expected register file
   row_t        exp_q [$];                              // fetched, not yet issued
   bit          ack_hold;                               // withhold issue ack
   int          errs;
   int          n_checks;
   int          n_issued;
   int          n_fetched;

   dec_top i_dec_top (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;                           // 100 ns period
   end

   // ************************************************************
   // checks
   // ************************************************************
   task automatic compare_val(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      n_checks++;
      if (got !== exp) begin
         errs++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_issue();
      row_t r;
      if (exp_q.size() == 0) begin
         errs++;
         $display("issue with no instruction outstanding, pc %h", iss_pc);
         return;
      end
      r = exp_q.pop_front();
      compare_val("iss_pc", 32'(iss_pc), 32'(r.pc));
      compare_val("iss_illegal", 32'(iss_illegal), 32'(r.illegal));
      if (!r.illegal) begin
         compare_val("iss_unit", 32'(iss_unit), 32'(r.unit));
         compare_val("iss_alu_op", 32'(iss_alu_op), 32'(r.alu_op));
         compare_val("iss_rd", 32'(iss_rd), 32'(r.rd));
         compare_val("iss_rd_en", 32'(iss_rd_en), 32'(r.rd_en));
         compare_val("iss_imm", iss_imm, r.imm);
         compare_val("iss_rs1_data", iss_rs1_data, shadow[r.rs1]);  // shadow[0] stays 0
         compare_val("iss_rs2_data", iss_rs2_data, shadow[r.rs2]);
      end
   endtask

   // all fetched instructions presented and the last request closed
   task automatic wait_drain(input string what);
      int t;
      for (t = 0; t < 200 && (exp_q.size() != 0 || iss_req); t++) @(posedge clk);
      if (exp_q.size() != 0 || iss_req) begin
         errs++;
         $display("timeout, %0d instructions still outstanding %s", exp_q.size(), what);
      end
   endtask

   // ************************************************************
   // drivers
   // ************************************************************
   task automatic fetch(input row_t r, input logic [30:0] pc);
      int t;
      for (t = 0; t < 100 && ifu_ack; t++) @(posedge clk);  // previous ack closed
      if (ifu_ack) begin
         errs++;
         $display("timeout waiting for ifu_ack to fall, pc %h", pc);
      end
      @(posedge clk);
      ifu_req   <= 1'b1;
      ifu_instr <= r.instr;
      ifu_pc    <= pc;
      r.pc = pc;
      exp_q.push_back(r);
      for (t = 0; t < 100 && !ifu_ack; t++) @(posedge clk);
      if (!ifu_ack) begin
         errs++;
         $display("timeout waiting for ifu_ack, pc %h", pc);
      end
      n_fetched++;
      ifu_req <= 1'b0;
   endtask

   task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
      @(posedge clk);
      wb_wen   <= 1'b1;
      wb_waddr <= addr;
      wb_wdata <= data;
      if (addr != 5'd0) shadow[addr] = data;            // x0 write ignored
      @(posedge clk);
      wb_wen <= 1'b0;
   endtask

   initial begin : responder
      int t;
      int dly;
      void'($urandom(32'hb1ed_a1e1));
      iss_ack = 1'b0;
      forever begin
         @(posedge clk);
         if (iss_req && !iss_ack) begin
            check_issue();
            n_issued++;
            for (t = 0; t < 400 && ack_hold; t++) @(posedge clk);
            if (ack_hold) begin
               errs++;
               $display("timeout, issue ack held back too long");
            end
            dly = $urandom % 4;
            repeat (dly) @(posedge clk);
            iss_ack <= 1'b1;
            for (t = 0; t < 20 && iss_req; t++) @(posedge clk);
            if (iss_req) begin
               errs++;
               $display("timeout, iss_req did not fall after ack");
            end
            iss_ack <= 1'b0;
         end
      end
   end

   // ************************************************************
   // main sequence
   // ************************************************************
   initial begin : main
      int t;
      int target;
      rst_n     = 1'b0;
      flush     = 1'b0;
      ifu_req   = 1'b0;
      ifu_instr = '0;
      ifu_pc    = '0;
      wb_wen    = 1'b0;
      wb_waddr  = '0;
      wb_wdata  = '0;
      ack_hold  = 1'b0;
      for (t = 0; t < 32; t++) shadow[t] = '0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      write_reg(5'd1, 32'h11111111);                    // register preload
      write_reg(5'd2, 32'h22220002);
      write_reg(5'd3, 32'h00000333);
      write_reg(5'd4, 32'hfffffff4);
      write_reg(5'd0, 32'hdeadbeef);                    // must stay zero
      for (t = 0; t < ROWS; t++) fetch(rows[t], rows[t].pc);
      // bypass, second instruction waits in decode
      target = n_fetched + 2;
      ack_hold = 1'b1;
      fetch(rows[0], 31'h180);
      fetch(rows[1], 31'h181);                          // reads x3
      repeat (4) @(posedge clk);
      wb_wen   <= 1'b1;
      wb_waddr <= 5'd3;
      wb_wdata <= 32'h0bad0333;
      shadow[3] = 32'h0bad0333;
      ack_hold = 1'b0;
      for (t = 0; t < 100 && n_issued < target; t++) @(posedge clk);
      if (n_issued < target) begin
         errs++;
         $display("timeout, bypass instruction never issued");
      end
      wb_wen <= 1'b0;
      // back-pressure, six fill buffer plus both stages
      ack_hold = 1'b1;
      target = n_fetched + 6;
      fork
         for (int i = 0; i < 8; i++) fetch(rows[i], 31'h100 + 31'(i));
         begin
            repeat (45) @(posedge clk);
            compare_val("fetches_acked", 32'(n_fetched), 32'(target));
            compare_val("ifu_req", 32'(ifu_req), 32'd1);
            compare_val("ifu_ack", 32'(ifu_ack), 32'd0);   // stalled, buffer full
            ack_hold = 1'b0;
         end
      join
      wait_drain("before flush");
      // flush with the first request already up
      ack_hold = 1'b1;
      fetch(rows[3], 31'h200);
      fetch(rows[4], 31'h201);
      fetch(rows[5], 31'h202);
      for (t = 0; t < 100 && !iss_req; t++) @(posedge clk);
      if (!iss_req) begin
         errs++;
         $display("timeout waiting for iss_req before flush");
      end
      @(posedge clk);
      flush <= 1'b1;
      @(posedge clk);
      flush <= 1'b0;
      void'(exp_q.pop_back());                          // dropped by flush
      void'(exp_q.pop_back());
      ack_hold = 1'b0;
      fetch(rows[6], 31'h210);
      fetch(rows[7], 31'h211);
      wait_drain("at end of run");
      repeat (10) @(posedge clk);                       // catch stray issues
      $display("checks %0d, errors %0d", n_checks, errs);
      if (errs == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: src.f
+incdir+bench
hdl/dec_pkg.sv
hdl/dec_stage_if.sv
hdl/dec_ib_ctl.sv
hdl/dec_decode_ctl.sv
hdl/dec_gpr_ctl.sv
hdl/dec_issue_ctl.sv
hdl/dec_top.sv
bench/dec_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f src.f --top-module dec_tb -o dec_tb_sim --Mdir obj_dir
	./obj_dir/dec_tb_sim | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
